// ==== run_sim.sh ====
#!/bin/sh
# Build and run the neuron core testbench with Verilator.
# Exit status is 0 only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_snn_neuron_core \
    --Mdir obj_dir \
    -o tb_snn_neuron_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_snn_neuron_core > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== sources.f ====
+incdir+src
src/snn_pkg.sv
src/snn_if.sv
src/fp_add_sub.sv
src/lif_potential_update.sv
src/neuron_regs.sv
src/snn_neuron_core.sv
tests/snn_neuron_core_properties.sv
tests/tb_snn_neuron_core.sv

// ==== src/fp_add_sub.sv ====
// fp32 add/sub: truncates, flushes denormals to zero, returns infinity instead of NaN
`timescale 1ns/10ps
`default_nettype none

module fp_add_sub
    import snn_pkg::*;
(
    input  fp32_t a,
    input  fp32_t b,
    input  logic  sub,
    output fp32_t result,
    output logic  exception
);

    logic        sign_a;
    logic        sign_b;
    logic [30:0] mag_a;
    logic [30:0] mag_b;
    logic [26:0] man_a;
    logic [26:0] man_b;
    logic        a_big;
    logic        sign_big;
    logic [7:0]  exp_big;
    logic [7:0]  exp_small;
    logic [26:0] man_big;
    logic [26:0] man_small;
    logic [7:0]  shift;
    logic [26:0] man_shift;
    logic [27:0] sum;
    logic [4:0]  lzc;
    logic [26:0] norm;
    logic [9:0]  exp_norm;
    logic        in_special;
    logic        underflow;
    logic        overflow;

    // b negated for subtraction
    assign sign_a = a[31];
    assign sign_b = b[31] ^ sub;

    // exponent 255 means inf or nan on either side
    assign in_special = (a[30:23] == 8'hff) || (b[30:23] == 8'hff);

    // denormals count as zero
    assign mag_a = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
    assign mag_b = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];

    // hidden one plus three extra bits below the lsb
    assign man_a = {|mag_a[30:23], mag_a[22:0], 3'b000};
    assign man_b = {|mag_b[30:23], mag_b[22:0], 3'b000};

    // order by magnitude so the difference never goes negative
    assign a_big     = mag_a >= mag_b;
    assign sign_big  = a_big ? sign_a : sign_b;
    assign exp_big   = a_big ? mag_a[30:23] : mag_b[30:23];
    assign exp_small = a_big ? mag_b[30:23] : mag_a[30:23];
    assign man_big   = a_big ? man_a : man_b;
    assign man_small = a_big ? man_b : man_a;

    // align, bits shifted out are dropped
    assign shift     = exp_big - exp_small;
    assign man_shift = (shift > 8'd26) ? 27'd0 : (man_small >> shift);

    assign sum = (sign_a ^ sign_b) ? ({1'b0, man_big} - {1'b0, man_shift})
                                   : ({1'b0, man_big} + {1'b0, man_shift});

    // leading zeros below the carry bit
    always_comb begin
        lzc = 5'd0;
        for (int i = 0; i < 27; i++) begin
            if (sum[i]) begin
                lzc = 5'(26 - i);
            end
        end
    end

    // normalize, carry shifts right by one
    always_comb begin
        exp_norm = {2'b00, exp_big};
        if (sum[27]) begin
            norm     = sum[27:1];
            exp_norm = exp_norm + 10'd1;
        end else begin
            norm     = sum[26:0] << lzc;
            exp_norm = exp_norm - {5'd0, lzc};
        end
    end

    // bit 9 set means the exponent wrapped below zero
    assign underflow = exp_norm[9] || (exp_norm == 10'd0);
    assign overflow  = !exp_norm[9] && (exp_norm[8:0] >= 9'd255);

    always_comb begin
        exception = 1'b0;
        if (in_special || overflow) begin
            // saturate to infinity
            result    = {sign_big, 8'hff, 23'd0};
            exception = 1'b1;
        end else if ((sum == 28'd0) || underflow) begin
            // exact cancel gives +0
            result = 32'd0;
        end else begin
            // truncate the three extra bits
            result = {sign_big, exp_norm[7:0], norm[25:3]};
        end
    end

endmodule

`default_nettype wire

// ==== src/lif_potential_update.sv ====
// one LIF step per start, no leak; result valid with done one clock later
`timescale 1ns/10ps
`default_nettype none

module lif_potential_update
    import snn_pkg::*;
(
    input  logic clk_adder,
    input  logic rst,
    lif_if.dp    lif
);

    fp32_t sum;
    fp32_t diff;
    logic  exc_add;
    logic  exc_sub;
    logic  both_zero;
    logic  greater;

    // v + w
    fp_add_sub u_add (
        .a         (lif.potential),
        .b         (lif.weight),
        .sub       (1'b0),
        .result    (sum),
        .exception (exc_add)
    );

    // (v + w) - vth, used only on a spike
    fp_add_sub u_sub (
        .a         (sum),
        .b         (lif.threshold),
        .sub       (1'b1),
        .result    (diff),
        .exception (exc_sub)
    );

    // +0 and -0 compare equal
    assign both_zero = (sum[30:0] == 31'd0) && (lif.threshold[30:0] == 31'd0);

    // strict sum > threshold on sign and magnitude
    always_comb begin
        if (sum[31] != lif.threshold[31]) begin
            greater = !sum[31] && !both_zero;
        end else if (!sum[31]) begin
            greater = sum[30:0] > lif.threshold[30:0];
        end else begin
            // both negative, smaller magnitude wins
            greater = sum[30:0] < lif.threshold[30:0];
        end
    end

    always_ff @(posedge clk_adder) begin
        if (rst) begin
            lif.done <= 1'b0;
        end else begin
            lif.done <= lif.start;
        end
    end

    // result held until the next start
    always_ff @(posedge clk_adder) begin
        if (lif.start) begin
            lif.new_potential <= greater ? diff : sum;
            lif.fired         <= greater;
            lif.exception     <= exc_add || exc_sub;
            lif.idx_out       <= lif.idx;
        end
    end

endmodule

`default_nettype wire

// ==== src/neuron_regs.sv ====
// classic wishbone slave, full-word accesses only; a weight write holds off ack for 3 edges
`timescale 1ns/10ps
`default_nettype none

`include "snn_cfg.svh"

module neuron_regs
    import snn_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  wb_adr_t     adr,
    input  fp32_t       dat_w,
    output logic [31:0] dat_r,
    output logic        ack,
    output logic        spike,
    output neuron_idx_t spike_id,
    lif_if.ctrl         lif
);

    localparam wb_adr_t adr_threshold = wb_adr_t'(`SNN_REG_THRESHOLD);
    localparam wb_adr_t adr_spikes    = wb_adr_t'(`SNN_REG_SPIKES);
    localparam wb_adr_t adr_status    = wb_adr_t'(`SNN_REG_STATUS);
    localparam wb_adr_t adr_weight_lo = wb_adr_t'(`SNN_REG_WEIGHT_BASE);
    localparam wb_adr_t adr_weight_hi =
        wb_adr_t'(`SNN_REG_WEIGHT_BASE + `SNN_NUM_NEURONS - 1);

    bus_state_t                  state;
    fp32_t                       thr_q;
    logic [`SNN_NUM_NEURONS-1:0] spikes_q;
    logic                        exc_q;
    potential_t                  pot_mem [`SNN_NUM_NEURONS];
    logic                        req;
    logic                        is_weight;
    neuron_idx_t                 adr_idx;
    logic [31:0]                 rd_data;

    // new request only from IDLE, so a held stb during ack is not taken twice
    assign req       = cyc && stb && (state == IDLE);
    assign is_weight = (adr >= adr_weight_lo) && (adr <= adr_weight_hi);
    assign adr_idx   = neuron_idx_t'(adr - adr_weight_lo);

    assign ack           = (state == ACK);
    assign lif.threshold = thr_q;

    // read mux, unmapped addresses read zero
    always_comb begin
        rd_data = 32'd0;
        if (adr == adr_threshold) begin
            rd_data = thr_q;
        end else if (adr == adr_spikes) begin
            rd_data = {{(32 - `SNN_NUM_NEURONS){1'b0}}, spikes_q};
        end else if (adr == adr_status) begin
            rd_data[0] = exc_q;
        end else if (is_weight) begin
            rd_data = pot_mem[adr_idx];
        end
    end

    always_ff @(posedge clk_adder) begin
        if (rst) begin
            state     <= IDLE;
            thr_q     <= `SNN_RESET_THRESHOLD;
            spikes_q  <= '0;
            exc_q     <= 1'b0;
            spike     <= 1'b0;
            lif.start <= 1'b0;
            for (int n = 0; n < `SNN_NUM_NEURONS; n++) begin
                pot_mem[n] <= '0;
            end
        end else begin
            lif.start <= 1'b0;
            spike     <= 1'b0;
            case (state)
                IDLE: begin
                    if (req && we && is_weight) begin
                        // operands latched in the payload block below
                        lif.start <= 1'b1;
                        state     <= UPDATE;
                    end else if (req) begin
                        if (we && (adr == adr_threshold)) begin
                            thr_q <= dat_w;
                        end
                        // write one to clear
                        if (we && (adr == adr_spikes)) begin
                            spikes_q <= spikes_q & ~dat_w[`SNN_NUM_NEURONS-1:0];
                        end
                        if (we && (adr == adr_status) && dat_w[0]) begin
                            exc_q <= 1'b0;
                        end
                        state <= ACK;
                    end
                end
                UPDATE: begin
                    if (lif.done) begin
                        pot_mem[lif.idx_out]  <= lif.new_potential;
                        spikes_q[lif.idx_out] <= spikes_q[lif.idx_out] | lif.fired;
                        exc_q                 <= exc_q | lif.exception;
                        // pulse lines up with ack
                        spike                 <= lif.fired;
                        state                 <= ACK;
                    end
                end
                ACK: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // data path registers, qualified by ack, start and spike
    always_ff @(posedge clk_adder) begin
        if (req) begin
            dat_r         <= rd_data;
            lif.idx       <= adr_idx;
            lif.potential <= pot_mem[adr_idx];
            lif.weight    <= dat_w;
        end
        if ((state == UPDATE) && lif.done) begin
            spike_id <= lif.idx_out;
        end
    end

endmodule

`default_nettype wire

// ==== src/snn_cfg.svh ====
// core sizing and register map; the neuron count must stay a power of two up to 16
`ifndef SNN_CFG_SVH
`define SNN_CFG_SVH

// neurons in the core, one potential each
`define SNN_NUM_NEURONS 8

// wishbone word address width
`define SNN_ADR_W 5

// register word offsets
`define SNN_REG_THRESHOLD 0
`define SNN_REG_SPIKES 1
`define SNN_REG_STATUS 2
// weight n lives at base + n
`define SNN_REG_WEIGHT_BASE 16

// 40.0 in single precision
`define SNN_RESET_THRESHOLD 32'h42200000

`endif

// ==== src/snn_if.sv ====
// update request and result between register block and datapath; done follows start by one clock
`timescale 1ns/10ps
`default_nettype none

interface lif_if
    import snn_pkg::*;
();

    // request side, driven by the register block
    // one-cycle pulse
    logic        start;
    // neuron being updated
    neuron_idx_t idx;
    // stored potential of that neuron
    potential_t  potential;
    // incoming synaptic weight
    fp32_t       weight;
    // firing threshold
    fp32_t       threshold;

    // result side, driven by the datapath
    // one clock after start
    logic        done;
    // idx echoed back with the result
    neuron_idx_t idx_out;
    // potential to write back
    potential_t  new_potential;
    // sum went above threshold
    logic        fired;
    // inf/nan in or overflow out
    logic        exception;

    modport ctrl (
        output start, idx, potential, weight, threshold,
        input  done, idx_out, new_potential, fired, exception
    );

    modport dp (
        input  start, idx, potential, weight, threshold,
        output done, idx_out, new_potential, fired, exception
    );

endinterface

`default_nettype wire

// ==== src/snn_neuron_core.sv ====
// neuron core top; one wishbone request at a time, spike pulses together with ack
`timescale 1ns/10ps
`default_nettype none

module snn_neuron_core
    import snn_pkg::*;
(
    input  logic        clk_adder,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_adr_t     wb_adr,
    input  fp32_t       wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        spike,
    output neuron_idx_t spike_id
);

    // regs to datapath link
    lif_if lif_bus ();

    neuron_regs i_regs (
        .clk_adder (clk_adder),
        .rst       (rst),
        .cyc       (wb_cyc),
        .stb       (wb_stb),
        .we        (wb_we),
        .adr       (wb_adr),
        .dat_w     (wb_dat_w),
        .dat_r     (wb_dat_r),
        .ack       (wb_ack),
        .spike     (spike),
        .spike_id  (spike_id),
        .lif       (lif_bus.ctrl)
    );

    lif_potential_update i_lif (
        .clk_adder (clk_adder),
        .rst       (rst),
        .lif       (lif_bus.dp)
    );

endmodule

`default_nettype wire

// ==== src/snn_pkg.sv ====
// shared types of the neuron core; widths come from snn_cfg.svh, so include order matters
`default_nettype none

`include "snn_cfg.svh"

package snn_pkg;

    // raw IEEE-754 single precision word
    typedef logic [31:0] fp32_t;

    // membrane potential, kept as a float
    typedef fp32_t potential_t;

    // neuron number
    typedef logic [$clog2(`SNN_NUM_NEURONS)-1:0] neuron_idx_t;

    // wishbone word address
    typedef logic [`SNN_ADR_W-1:0] wb_adr_t;

    // bus FSM of neuron_regs
    typedef enum logic [1:0] {
        IDLE,
        UPDATE,
        ACK
    } bus_state_t;

endpackage

`default_nettype wire

// ==== tests/snn_neuron_core_properties.sv ====
// bus and spike rules for snn_neuron_core; assumes a master that holds stb until after ack
`timescale 1ns/10ps
`default_nettype none

module snn_neuron_core_properties (
    input logic clk_adder,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic spike
);

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk_adder) disable iff (rst) ack |=> !ack)
        else $error("wb_ack stayed high for two cycles");

    // no ack without a live request
    ack_needs_request: assert property (@(posedge clk_adder) disable iff (rst)
        ack |-> (cyc && stb))
        else $error("wb_ack high without wb_cyc and wb_stb");

    // spike comes out together with the weight write ack
    spike_with_ack: assert property (@(posedge clk_adder) disable iff (rst) spike |-> ack)
        else $error("spike high without wb_ack");

    // outputs quiet once reset has been seen for a cycle
    quiet_in_reset: assert property (@(posedge clk_adder)
        (rst && $past(rst)) |-> (!ack && !spike))
        else $error("wb_ack or spike high during reset");

endmodule

bind snn_neuron_core snn_neuron_core_properties u_props (
    .clk_adder (clk_adder),
    .rst       (rst),
    .cyc       (wb_cyc),
    .stb       (wb_stb),
    .ack       (wb_ack),
    .spike     (spike)
);

`default_nettype wire

// ==== tests/tb_snn_neuron_core.sv ====
// drives the core over wishbone from a table; all weights are exact floats so sums need no rounding
`timescale 1ns/10ps
`default_nettype none

`include "snn_cfg.svh"

module tb_snn_neuron_core
    import snn_pkg::*;
();

    localparam int NUM_N     = `SNN_NUM_NEURONS;
    localparam int IDX_W     = $clog2(NUM_N);
    localparam int TBL_LEN   = 27;
    localparam int ACK_LIMIT = 16;
    // every table row gets 10 cycles, the shuffle row gets N*N more
    localparam longint WATCHDOG_NS = (TBL_LEN + NUM_N * NUM_N) * 10 * 100 + 5 * 100;

    typedef enum logic [2:0] {
        OP_THRESHOLD,
        OP_WEIGHT,
        OP_READ,
        OP_CLEAR,
        OP_SHUFFLE
    } op_t;

    typedef struct packed {
        op_t         op;
        wb_adr_t     adr;
        logic [31:0] data;
        // read data, or the potential after a weight step
        logic [31:0] exp_rd;
        logic        exp_spike;
        neuron_idx_t exp_id;
    } row_t;

    logic        clk_adder;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_adr_t     wb_adr;
    fp32_t       wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        spike;
    neuron_idx_t spike_id;

    row_t        tbl [TBL_LEN];
    logic [31:0] exp_pot [NUM_N];
    logic [31:0] shuffle_exp [NUM_N];
    logic [31:0] lfsr_state = 32'hf19bf5eb;

    snn_neuron_core i_snn_neuron_core (
        .clk_adder (clk_adder),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .spike     (spike),
        .spike_id  (spike_id)
    );

    initial begin
        clk_adder = 1'b0;
        forever #50 clk_adder = ~clk_adder;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $fatal(1);
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out_bit ? 32'h80200003 : 32'h0);
        return out_bit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
        assert (got_val === exp_val) else begin
            $display("mismatch %s exp=%h got=%h", name, exp_val, got_val);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // one classic cycle, called and left on a falling edge
    task automatic bus_transfer(input wb_adr_t adr, input logic we, input fp32_t dat,
                                output logic [31:0] rd, output logic spk,
                                output neuron_idx_t id);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        do begin
            @(negedge clk_adder);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("no wb_ack within %0d cycles at address %h", ACK_LIMIT, adr);
                $display("sim failed");
                $fatal(1);
            end
        end while (!wb_ack);
        rd  = wb_dat_r;
        spk = spike;
        id  = spike_id;
        // stb dropped in the cycle after ack
        @(negedge clk_adder);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_adr_t adr, input fp32_t dat, output logic spk,
                            output neuron_idx_t id);
        logic [31:0] unused_rd;
        bus_transfer(adr, 1'b1, dat, unused_rd, spk, id);
    endtask

    task automatic wb_read(input wb_adr_t adr, output logic [31:0] rd);
        logic        spk;
        neuron_idx_t id;
        bus_transfer(adr, 1'b0, 32'd0, rd, spk, id);
        check_value("spike", 32'd0, {31'd0, spk});
    endtask

    task automatic check_potentials();
        logic [31:0] rd;
        for (int n = 0; n < NUM_N; n++) begin
            wb_read(wb_adr_t'(`SNN_REG_WEIGHT_BASE + n), rd);
            check_value("wb_dat_r", exp_pot[n], rd);
        end
    endtask

    // every neuron once, in LFSR order, all potentials checked after each step
    task automatic shuffle_weights(input fp32_t weight);
        logic [NUM_N-1:0] visited;
        neuron_idx_t      pick;
        int               tries;
        logic             spk;
        neuron_idx_t      id;
        visited = '0;
        tries   = 0;
        while (visited != '1) begin
            for (int b = 0; b < IDX_W; b++) begin
                pick[b] = next_random_bit();
            end
            tries++;
            if (tries > 1000) begin
                $display("random order never reached every neuron");
                $display("sim failed");
                $fatal(1);
            end
            if (!visited[pick]) begin
                visited[pick] = 1'b1;
                wb_write(wb_adr_t'(`SNN_REG_WEIGHT_BASE + pick), weight, spk, id);
                check_value("spike", 32'd0, {31'd0, spk});
                exp_pot[pick] = shuffle_exp[pick];
                check_potentials();
            end
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        spk;
        neuron_idx_t id;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int n = 0; n < NUM_N; n++) begin
            exp_pot[n] = 32'd0;
        end
        // state before the shuffle row is 0, 40, 0, 5, 0, -3, 0, 0 with threshold 1000
        shuffle_exp = '{32'h3f800000, 32'h42240000, 32'h3f800000, 32'h40c00000,
                        32'h3f800000, 32'hc0000000, 32'h3f800000, 32'h3f800000};
        // reset values
        tbl[0]  = '{OP_READ, 5'd0, 32'h0, 32'h42200000, 1'b0, 3'd0};
        tbl[1]  = '{OP_READ, 5'd1, 32'h0, 32'h0, 1'b0, 3'd0};
        tbl[2]  = '{OP_READ, 5'd2, 32'h0, 32'h0, 1'b0, 3'd0};
        // 10 + 20 stays under 40
        tbl[3]  = '{OP_WEIGHT, 5'd19, 32'h41200000, 32'h41200000, 1'b0, 3'd0};
        tbl[4]  = '{OP_WEIGHT, 5'd19, 32'h41a00000, 32'h41f00000, 1'b0, 3'd0};
        tbl[5]  = '{OP_READ, 5'd1, 32'h0, 32'h0, 1'b0, 3'd0};
        // 30 + 15 = 45 fires, leaves 5
        tbl[6]  = '{OP_WEIGHT, 5'd19, 32'h41700000, 32'h40a00000, 1'b1, 3'd3};
        tbl[7]  = '{OP_READ, 5'd1, 32'h0, 32'h8, 1'b0, 3'd0};
        // exactly 40 does not fire
        tbl[8]  = '{OP_WEIGHT, 5'd17, 32'h42200000, 32'h42200000, 1'b0, 3'd0};
        tbl[9]  = '{OP_READ, 5'd1, 32'h0, 32'h8, 1'b0, 3'd0};
        // threshold 2.0, then 3.0 fires to 1.0 and -4.0 gives -3.0
        tbl[10] = '{OP_THRESHOLD, 5'd0, 32'h40000000, 32'h0, 1'b0, 3'd0};
        tbl[11] = '{OP_READ, 5'd0, 32'h0, 32'h40000000, 1'b0, 3'd0};
        tbl[12] = '{OP_WEIGHT, 5'd21, 32'h40400000, 32'h3f800000, 1'b1, 3'd5};
        tbl[13] = '{OP_WEIGHT, 5'd21, 32'hc0800000, 32'hc0400000, 1'b0, 3'd0};
        tbl[14] = '{OP_READ, 5'd1, 32'h0, 32'h28, 1'b0, 3'd0};
        // write one to clear, one bit at a time
        tbl[15] = '{OP_CLEAR, 5'd1, 32'h8, 32'h0, 1'b0, 3'd0};
        tbl[16] = '{OP_READ, 5'd1, 32'h0, 32'h20, 1'b0, 3'd0};
        tbl[17] = '{OP_CLEAR, 5'd1, 32'h20, 32'h0, 1'b0, 3'd0};
        tbl[18] = '{OP_READ, 5'd1, 32'h0, 32'h0, 1'b0, 3'd0};
        // threshold 1000.0 so the shuffle never fires
        tbl[19] = '{OP_THRESHOLD, 5'd0, 32'h447a0000, 32'h0, 1'b0, 3'd0};
        tbl[20] = '{OP_SHUFFLE, 5'd0, 32'h3f800000, 32'h0, 1'b0, 3'd0};
        tbl[21] = '{OP_READ, 5'd1, 32'h0, 32'h0, 1'b0, 3'd0};
        // +inf is above any threshold and raises the exception
        tbl[22] = '{OP_WEIGHT, 5'd22, 32'h7f800000, 32'h7f800000, 1'b1, 3'd6};
        tbl[23] = '{OP_READ, 5'd2, 32'h0, 32'h1, 1'b0, 3'd0};
        tbl[24] = '{OP_CLEAR, 5'd2, 32'h1, 32'h0, 1'b0, 3'd0};
        tbl[25] = '{OP_READ, 5'd2, 32'h0, 32'h0, 1'b0, 3'd0};
        tbl[26] = '{OP_READ, 5'd1, 32'h0, 32'h40, 1'b0, 3'd0};

        repeat (5) @(posedge clk_adder);
        @(negedge clk_adder);
        rst = 1'b0;
        check_potentials();

        for (int r = 0; r < TBL_LEN; r++) begin
            case (tbl[r].op)
                OP_READ: begin
                    wb_read(tbl[r].adr, rd);
                    check_value("wb_dat_r", tbl[r].exp_rd, rd);
                end
                OP_WEIGHT: begin
                    wb_write(tbl[r].adr, tbl[r].data, spk, id);
                    check_value("spike", {31'd0, tbl[r].exp_spike}, {31'd0, spk});
                    if (tbl[r].exp_spike) begin
                        check_value("spike_id", {29'd0, tbl[r].exp_id}, {29'd0, id});
                    end
                    // only the written neuron may change
                    exp_pot[neuron_idx_t'(tbl[r].adr - wb_adr_t'(`SNN_REG_WEIGHT_BASE))] =
                        tbl[r].exp_rd;
                    check_potentials();
                end
                OP_SHUFFLE: begin
                    shuffle_weights(tbl[r].data);
                end
                default: begin
                    wb_write(tbl[r].adr, tbl[r].data, spk, id);
                    check_value("spike", 32'd0, {31'd0, spk});
                end
            endcase
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
